/* hdl/multi_uart_config.svh */
`ifndef MULTI_UART_CONFIG_SVH
`define MULTI_UART_CONFIG_SVH

// number of serial ports, a power of two from 2 to 8.
`define UART_PORTS 4

// width of the port field, keep equal to log2 of UART_PORTS.
`define UART_PORT_BITS 2

// clocks per serial bit.
`define UART_CLKS_PER_BIT 8

`define UART_REG_BITS 3

// byte address bit where the register index starts.
`define UART_ADDR_LSB 2

// width of the internal byte bus address: port field over register index.
`define UART_BUS_ADDR_BITS (`UART_PORT_BITS + `UART_REG_BITS)

`endif

/* hdl/axi_lite_pkg.sv */
`default_nettype none

package axi_lite_pkg;

	// response codes used by the slave.
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10
	} axi_resp_e;

	typedef enum logic [1:0] {
		IDLE,
		WRITE_RESP, // bvalid held until bready.
		READ_RESP   // rvalid held until rready.
	} bridge_state_e;

endpackage

`default_nettype wire

/* hdl/uart_pkg.sv */
`default_nettype none

`include "multi_uart_config.svh"

package uart_pkg;

	// 16550 style register indices, the rest are unmapped.
	typedef enum logic [`UART_REG_BITS-1:0] {
		REG_DATA    = 0, // rbr on read, thr on write.
		REG_IER     = 1,
		REG_LSR     = 5,
		REG_SCRATCH = 7
	} reg_index_e;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START, // waiting for mid start bit.
		RX_DATA,
		RX_STOP
	} rx_state_e;

endpackage

`default_nettype wire

/* hdl/axi_byte_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

`include "multi_uart_config.svh"

module axi_byte_bridge (
	input  wire         aclk,
	input  wire         rst_i,

	input  wire  [31:0] axi_s_awaddr_i,
	input  wire         axi_s_awvalid_i,
	output logic        axi_s_awready_o,

	input  wire  [31:0] axi_s_wdata_i,
	input  wire  [3:0]  axi_s_wstrb_i,
	input  wire         axi_s_wvalid_i,
	output logic        axi_s_wready_o,

	output logic [1:0]  axi_s_bresp_o,
	output logic        axi_s_bvalid_o,
	input  wire         axi_s_bready_i,

	input  wire  [31:0] axi_s_araddr_i,
	input  wire         axi_s_arvalid_i,
	output logic        axi_s_arready_o,

	output logic [31:0] axi_s_rdata_o,
	output logic [1:0]  axi_s_rresp_o,
	output logic        axi_s_rvalid_o,
	input  wire         axi_s_rready_i,

	output logic [`UART_BUS_ADDR_BITS-1:0] reg_addr_o,
	output logic [7:0]  reg_wdata_o,
	output logic        reg_we_o,
	output logic        reg_re_o,
	output logic        addr_err_o,
	input  wire  [7:0]  reg_rdata_i
);

	axi_lite_pkg::bridge_state_e state_q;
	axi_lite_pkg::axi_resp_e resp_q;
	logic [31:0] rdata_q;
	logic wr_pend;
	logic wr_fire;
	logic rd_fire;
	logic [31:0] addr_sel;
	logic [`UART_REG_BITS-1:0] index_sel;
	logic range_bad;
	logic index_bad;

	assign wr_pend = axi_s_awvalid_i && axi_s_wvalid_i; // a write wins over a read.
	assign wr_fire = (state_q == axi_lite_pkg::IDLE) && wr_pend;
	assign rd_fire = (state_q == axi_lite_pkg::IDLE) && !wr_pend && axi_s_arvalid_i;

	assign addr_sel = wr_pend ? axi_s_awaddr_i : axi_s_araddr_i;
	assign index_sel = addr_sel[`UART_ADDR_LSB +: `UART_REG_BITS];
	assign range_bad = |(addr_sel >> (`UART_ADDR_LSB + `UART_BUS_ADDR_BITS));

	always_comb begin
		case (uart_pkg::reg_index_e'(index_sel))
			uart_pkg::REG_DATA,
			uart_pkg::REG_IER,
			uart_pkg::REG_LSR,
			uart_pkg::REG_SCRATCH: index_bad = 1'b0;
			default:               index_bad = 1'b1;
		endcase
	end

	assign addr_err_o = range_bad || index_bad;
	assign reg_addr_o = addr_sel[`UART_ADDR_LSB +: `UART_BUS_ADDR_BITS];
	assign reg_wdata_o = axi_s_wdata_i[7:0];
	assign reg_we_o = wr_fire && !addr_err_o && axi_s_wstrb_i[0];
	assign reg_re_o = rd_fire && !addr_err_o;

	assign axi_s_awready_o = wr_fire;
	assign axi_s_wready_o = wr_fire;
	assign axi_s_arready_o = rd_fire;

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			state_q <= axi_lite_pkg::IDLE;
		end else begin
			case (state_q)
				axi_lite_pkg::IDLE: begin
					if (wr_fire)
						state_q <= axi_lite_pkg::WRITE_RESP;
					else if (rd_fire)
						state_q <= axi_lite_pkg::READ_RESP;
				end
				axi_lite_pkg::WRITE_RESP: if (axi_s_bready_i) state_q <= axi_lite_pkg::IDLE;
				axi_lite_pkg::READ_RESP: if (axi_s_rready_i) state_q <= axi_lite_pkg::IDLE;
				default: state_q <= axi_lite_pkg::IDLE;
			endcase
		end
	end

	// one response register serves both channels, only one transfer is open.
	always_ff @(posedge aclk) begin
		if (wr_fire || rd_fire)
			resp_q <= addr_err_o ? axi_lite_pkg::SLVERR : axi_lite_pkg::OKAY;
		if (rd_fire)
			rdata_q <= {24'h000000, reg_rdata_i};
	end

	assign axi_s_bvalid_o = (state_q == axi_lite_pkg::WRITE_RESP);
	assign axi_s_rvalid_o = (state_q == axi_lite_pkg::READ_RESP);
	assign axi_s_bresp_o = resp_q;
	assign axi_s_rresp_o = resp_q;
	assign axi_s_rdata_o = rdata_q;

endmodule

`default_nettype wire

/* hdl/uart_line.sv */
`timescale 1ns/1ps
`default_nettype none

`include "multi_uart_config.svh"

module uart_line (
	input  wire        aclk,
	input  wire        rst_i,
	input  wire        tx_load_i,
	input  wire  [7:0] tx_byte_i,
	output logic       tx_busy_o,
	output logic       txd_o,
	output logic       rx_valid_o,
	input  wire        rxd_i,
	output logic [7:0] rx_byte_o
);

	localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(`UART_CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] BIT_HALF = CNT_W'(`UART_CLKS_PER_BIT / 2 - 1);

	uart_pkg::tx_state_e tx_state_q;
	logic [CNT_W-1:0] tx_cnt_q;
	logic [2:0] tx_bit_q;
	logic [7:0] tx_shift_q;

	uart_pkg::rx_state_e rx_state_q;
	logic [CNT_W-1:0] rx_cnt_q;
	logic [2:0] rx_bit_q;
	logic [7:0] rx_shift_q;
	logic rxd_meta_q;
	logic rxd_sync_q;
	logic rxd_prev_q;

	assign tx_busy_o = (tx_state_q != uart_pkg::TX_IDLE);
	assign rx_byte_o = rx_shift_q;

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			tx_state_q <= uart_pkg::TX_IDLE;
			tx_cnt_q <= '0;
			tx_bit_q <= 3'd0;
			txd_o <= 1'b1;
		end else begin
			tx_cnt_q <= (tx_cnt_q == BIT_LAST) ? '0 : tx_cnt_q + 1'b1;
			case (tx_state_q)
				uart_pkg::TX_IDLE: begin
					tx_cnt_q <= '0;
					if (tx_load_i) begin
						tx_shift_q <= tx_byte_i;
						tx_state_q <= uart_pkg::TX_START;
						txd_o <= 1'b0; // start bit.
					end
				end
				uart_pkg::TX_START: if (tx_cnt_q == BIT_LAST) begin
					tx_bit_q <= 3'd0;
					txd_o <= tx_shift_q[0];
					tx_state_q <= uart_pkg::TX_DATA;
				end
				uart_pkg::TX_DATA: if (tx_cnt_q == BIT_LAST) begin
					if (tx_bit_q == 3'd7) begin
						txd_o <= 1'b1; // stop bit.
						tx_state_q <= uart_pkg::TX_STOP;
					end else begin
						tx_bit_q <= tx_bit_q + 3'd1;
						tx_shift_q <= {1'b0, tx_shift_q[7:1]};
						txd_o <= tx_shift_q[1];
					end
				end
				default: if (tx_cnt_q == BIT_LAST) tx_state_q <= uart_pkg::TX_IDLE;
			endcase
		end
	end

	// two flop synchronizer plus one more for the edge.
	always_ff @(posedge aclk) begin
		if (rst_i) begin
			rxd_meta_q <= 1'b1;
			rxd_sync_q <= 1'b1;
			rxd_prev_q <= 1'b1;
		end else begin
			rxd_meta_q <= rxd_i;
			rxd_sync_q <= rxd_meta_q;
			rxd_prev_q <= rxd_sync_q;
		end
	end

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			rx_state_q <= uart_pkg::RX_IDLE;
			rx_cnt_q <= '0;
			rx_bit_q <= 3'd0;
			rx_valid_o <= 1'b0;
		end else begin
			rx_valid_o <= 1'b0;
			rx_cnt_q <= rx_cnt_q + 1'b1;
			case (rx_state_q)
				uart_pkg::RX_IDLE: begin
					rx_cnt_q <= '0;
					if (rxd_prev_q && !rxd_sync_q)
						rx_state_q <= uart_pkg::RX_START;
				end
				uart_pkg::RX_START: if (rx_cnt_q == BIT_HALF) begin
					rx_cnt_q <= '0;
					rx_bit_q <= 3'd0;
					// a glitch that is high again at mid-bit is not a start bit.
					rx_state_q <= rxd_sync_q ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
				end
				uart_pkg::RX_DATA: if (rx_cnt_q == BIT_LAST) begin
					rx_cnt_q <= '0;
					rx_shift_q <= {rxd_sync_q, rx_shift_q[7:1]}; // lsb first.
					rx_bit_q <= rx_bit_q + 3'd1;
					if (rx_bit_q == 3'd7)
						rx_state_q <= uart_pkg::RX_STOP;
				end
				default: if (rx_cnt_q == BIT_LAST) begin
					rx_valid_o <= 1'b1;
					rx_state_q <= uart_pkg::RX_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* hdl/uart_port.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_port (
	input  wire                 aclk,
	input  wire                 rst_i,
	input  wire uart_pkg::reg_index_e reg_index_i,
	input  wire  [7:0]          wdata_i,
	input  wire                 we_i,
	input  wire                 re_i,
	output logic [7:0]          rdata_o,
	input  wire                 rxd_i,
	output logic                txd_o,
	output logic                irq_o
);

	logic [1:0] ier_q;
	logic [7:0] scratch_q;
	logic [7:0] thr_q;
	logic thr_full_q;
	logic [7:0] rbr_q;
	logic dr_q;
	logic oe_q;
	logic tx_load;
	logic tx_busy;
	logic rx_valid;
	logic [7:0] rx_byte;
	logic thre;
	logic temt;
	logic [7:0] lsr;

	assign thre = !thr_full_q;
	assign temt = thre && !tx_busy;
	assign lsr = {1'b0, temt, thre, 3'b000, oe_q, dr_q};
	assign tx_load = thr_full_q && !tx_busy; // hand the byte to an idle shifter.

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			ier_q <= 2'b00;
			scratch_q <= 8'h00;
			thr_full_q <= 1'b0;
		end else begin
			if (we_i && reg_index_i == uart_pkg::REG_IER)
				ier_q <= wdata_i[1:0];
			if (we_i && reg_index_i == uart_pkg::REG_SCRATCH)
				scratch_q <= wdata_i;
			if (tx_load)
				thr_full_q <= 1'b0;
			else if (we_i && reg_index_i == uart_pkg::REG_DATA)
				thr_full_q <= 1'b1;
		end
	end

	// a write to a full holding register is dropped.
	always_ff @(posedge aclk) begin
		if (we_i && reg_index_i == uart_pkg::REG_DATA && !thr_full_q)
			thr_q <= wdata_i;
		if (rx_valid)
			rbr_q <= rx_byte;
	end

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			dr_q <= 1'b0;
			oe_q <= 1'b0;
		end else begin
			if (re_i && reg_index_i == uart_pkg::REG_DATA)
				dr_q <= 1'b0;
			if (re_i && reg_index_i == uart_pkg::REG_LSR)
				oe_q <= 1'b0;
			if (rx_valid) begin // a new byte wins over a same cycle read.
				dr_q <= 1'b1;
				if (dr_q)
					oe_q <= 1'b1;
			end
		end
	end

	always_comb begin
		case (reg_index_i)
			uart_pkg::REG_DATA:    rdata_o = rbr_q;
			uart_pkg::REG_IER:     rdata_o = {6'b000000, ier_q};
			uart_pkg::REG_LSR:     rdata_o = lsr;
			uart_pkg::REG_SCRATCH: rdata_o = scratch_q;
			default:               rdata_o = 8'h00;
		endcase
	end

	assign irq_o = (ier_q[0] && dr_q) || (ier_q[1] && thre);

	uart_line u_line (
		.aclk       (aclk),
		.rst_i      (rst_i),
		.tx_load_i  (tx_load),
		.tx_byte_i  (thr_q),
		.tx_busy_o  (tx_busy),
		.txd_o      (txd_o),
		.rx_valid_o (rx_valid),
		.rxd_i      (rxd_i),
		.rx_byte_o  (rx_byte)
	);

endmodule

`default_nettype wire

/* hdl/multi_uart.sv */
`timescale 1ns/1ps
`default_nettype none

`include "multi_uart_config.svh"

module multi_uart (
	input  wire         aclk,
	input  wire         rst_i,

	input  wire  [31:0] axi_s_awaddr_i,
	input  wire         axi_s_awvalid_i,
	output logic        axi_s_awready_o,

	input  wire  [31:0] axi_s_wdata_i,
	input  wire  [3:0]  axi_s_wstrb_i,
	input  wire         axi_s_wvalid_i,
	output logic        axi_s_wready_o,

	output logic [1:0]  axi_s_bresp_o,
	output logic        axi_s_bvalid_o,
	input  wire         axi_s_bready_i,

	input  wire  [31:0] axi_s_araddr_i,
	input  wire         axi_s_arvalid_i,
	output logic        axi_s_arready_o,

	output logic [31:0] axi_s_rdata_o,
	output logic [1:0]  axi_s_rresp_o,
	output logic        axi_s_rvalid_o,
	input  wire         axi_s_rready_i,

	input  wire  [`UART_PORTS-1:0] rxd_i,
	output logic [`UART_PORTS-1:0] txd_o,
	output logic                   interrupt_o
);

	logic [`UART_BUS_ADDR_BITS-1:0] reg_addr;
	logic [7:0] reg_wdata;
	logic reg_we;
	logic reg_re;
	logic addr_err;
	logic [7:0] reg_rdata;
	logic [`UART_PORT_BITS-1:0] reg_port;
	uart_pkg::reg_index_e reg_index;
	logic [7:0] port_rdata [`UART_PORTS];
	logic [`UART_PORTS-1:0] port_irq;

	assign reg_port = reg_addr[`UART_BUS_ADDR_BITS-1:`UART_REG_BITS];
	assign reg_index = uart_pkg::reg_index_e'(reg_addr[`UART_REG_BITS-1:0]);
	assign reg_rdata = addr_err ? 8'h00 : port_rdata[reg_port]; // error reads return zero.
	assign interrupt_o = |port_irq;

	axi_byte_bridge u_bridge (
		.aclk            (aclk),
		.rst_i           (rst_i),
		.axi_s_awaddr_i  (axi_s_awaddr_i),
		.axi_s_awvalid_i (axi_s_awvalid_i),
		.axi_s_awready_o (axi_s_awready_o),
		.axi_s_wdata_i   (axi_s_wdata_i),
		.axi_s_wstrb_i   (axi_s_wstrb_i),
		.axi_s_wvalid_i  (axi_s_wvalid_i),
		.axi_s_wready_o  (axi_s_wready_o),
		.axi_s_bresp_o   (axi_s_bresp_o),
		.axi_s_bvalid_o  (axi_s_bvalid_o),
		.axi_s_bready_i  (axi_s_bready_i),
		.axi_s_araddr_i  (axi_s_araddr_i),
		.axi_s_arvalid_i (axi_s_arvalid_i),
		.axi_s_arready_o (axi_s_arready_o),
		.axi_s_rdata_o   (axi_s_rdata_o),
		.axi_s_rresp_o   (axi_s_rresp_o),
		.axi_s_rvalid_o  (axi_s_rvalid_o),
		.axi_s_rready_i  (axi_s_rready_i),
		.reg_addr_o      (reg_addr),
		.reg_wdata_o     (reg_wdata),
		.reg_we_o        (reg_we),
		.reg_re_o        (reg_re),
		.addr_err_o      (addr_err),
		.reg_rdata_i     (reg_rdata)
	);

	for (genvar i = 0; i < `UART_PORTS; i++) begin : g_port
		logic sel;

		assign sel = (reg_port == `UART_PORT_BITS'(i));

		uart_port u_port (
			.aclk        (aclk),
			.rst_i       (rst_i),
			.reg_index_i (reg_index),
			.wdata_i     (reg_wdata),
			.we_i        (reg_we && sel),
			.re_i        (reg_re && sel),
			.rdata_o     (port_rdata[i]),
			.rxd_i       (rxd_i[i]),
			.txd_o       (txd_o[i]),
			.irq_o       (port_irq[i])
		);
	end

endmodule

`default_nettype wire

/* tests/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
	output logic clk_o,
	output logic rst_o
);

	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o; // 8 ns period.
	end

	initial begin
		rst_o = 1'b1;
		repeat (4) @(posedge clk_o);
		rst_o <= 1'b0;
	end

endmodule

`default_nettype wire

/* tests/multi_uart_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

`include "multi_uart_config.svh"

module multi_uart_assertions (
	input wire                   aclk,
	input wire                   rst_i,
	input wire                   bvalid_i,
	input wire                   bready_i,
	input wire                   rvalid_i,
	input wire                   rready_i,
	input wire [`UART_PORTS-1:0] txd_i
);

	// a valid once raised is held until its ready.
	a_b_hold: assert property (@(posedge aclk) disable iff (rst_i)
		bvalid_i && !bready_i |=> bvalid_i)
		else $error("bvalid dropped before bready");

	a_r_hold: assert property (@(posedge aclk) disable iff (rst_i)
		rvalid_i && !rready_i |=> rvalid_i)
		else $error("rvalid dropped before rready");

	a_one_resp: assert property (@(posedge aclk) disable iff (rst_i)
		!(bvalid_i && rvalid_i))
		else $error("bvalid and rvalid high together");

	for (genvar i = 0; i < `UART_PORTS; i++) begin : g_txd
		// line idles high between frames.
		a_txd_idle: assert property (@(posedge aclk) disable iff (rst_i)
			!g_port[i].u_port.tx_busy |-> txd_i[i])
			else $error("txd_o low while the transmitter is idle");
	end

endmodule

bind multi_uart multi_uart_assertions u_assertions (
	.aclk     (aclk),
	.rst_i    (rst_i),
	.bvalid_i (axi_s_bvalid_o),
	.bready_i (axi_s_bready_i),
	.rvalid_i (axi_s_rvalid_o),
	.rready_i (axi_s_rready_i),
	.txd_i    (txd_o)
);

`default_nettype wire

/* tests/multi_uart_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "multi_uart_config.svh"

module multi_uart_tb;

	localparam int MAX_RECORDS = 64;
	localparam int MAX_WORDS = MAX_RECORDS * 6;
	localparam int POLL_LIMIT = 200;

	logic aclk;
	logic rst;
	logic [31:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [31:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic [`UART_PORTS-1:0] rxd;
	logic [`UART_PORTS-1:0] txd;
	logic irq;

	logic [15:0] stim_mem [MAX_WORDS];
	int records;
	int cycles = 0;
	int cycle_limit = 0;

	clock_gen u_clock_gen (
		.clk_o (aclk),
		.rst_o (rst)
	);

	multi_uart u_multi_uart (
		.aclk            (aclk),
		.rst_i           (rst),
		.axi_s_awaddr_i  (awaddr),
		.axi_s_awvalid_i (awvalid),
		.axi_s_awready_o (awready),
		.axi_s_wdata_i   (wdata),
		.axi_s_wstrb_i   (wstrb),
		.axi_s_wvalid_i  (wvalid),
		.axi_s_wready_o  (wready),
		.axi_s_bresp_o   (bresp),
		.axi_s_bvalid_o  (bvalid),
		.axi_s_bready_i  (bready),
		.axi_s_araddr_i  (araddr),
		.axi_s_arvalid_i (arvalid),
		.axi_s_arready_o (arready),
		.axi_s_rdata_o   (rdata),
		.axi_s_rresp_o   (rresp),
		.axi_s_rvalid_o  (rvalid),
		.axi_s_rready_i  (rready),
		.rxd_i           (rxd),
		.txd_o           (txd),
		.interrupt_o     (irq)
	);

	assign rxd = {txd[`UART_PORTS-2:0], txd[`UART_PORTS-1]}; // port i feeds port i+1.

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	always @(posedge aclk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit)
			stop_on_error("the run timed out before the last stimulus record");
	end

	// register index in bits 4:2, port field above it.
	function automatic logic [31:0] reg_address(input int port, input int index);
		return (32'(port) << (`UART_ADDR_LSB + `UART_REG_BITS)) | (32'(index) << `UART_ADDR_LSB);
	endfunction

	// read data is a byte zero-extended to the full bus width.
	task automatic check_data(input string name, input logic [31:0] got, input logic [7:0] exp);
		if (got !== {24'h000000, exp})
			stop_on_error($sformatf("Error: %s expected 0x%08h got 0x%08h",
				name, {24'h000000, exp}, got));
	endtask

	task automatic check_resp(input string name, input axi_lite_pkg::axi_resp_e got,
			input axi_lite_pkg::axi_resp_e exp);
		if (got !== exp)
			stop_on_error($sformatf("Error: %s expected 0x%0h got 0x%0h", name, exp, got));
	endtask

	task automatic check_irq(input logic got, input logic exp);
		if (got !== exp)
			stop_on_error($sformatf("Error: interrupt_o expected 0x%0h got 0x%0h", exp, got));
	endtask

	task automatic write_register(input logic [31:0] addr, input logic [7:0] data,
			output axi_lite_pkg::axi_resp_e resp);
		int delay;
		@(posedge aclk);
		awaddr <= addr;
		wdata <= {24'h000000, data};
		wstrb <= 4'h1;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		do begin
			@(negedge aclk);
		end while (!(awready && wready));
		@(posedge aclk);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		delay = $urandom % 4;
		repeat (delay) @(posedge aclk);
		bready <= 1'b1;
		do begin
			@(negedge aclk);
		end while (!bvalid);
		resp = axi_lite_pkg::axi_resp_e'(bresp);
		@(posedge aclk);
		bready <= 1'b0;
	endtask

	task automatic read_register(input logic [31:0] addr, output logic [31:0] data,
			output axi_lite_pkg::axi_resp_e resp);
		int delay;
		@(posedge aclk);
		araddr <= addr;
		arvalid <= 1'b1;
		do begin
			@(negedge aclk);
		end while (!arready);
		@(posedge aclk);
		arvalid <= 1'b0;
		delay = $urandom % 4;
		repeat (delay) @(posedge aclk);
		rready <= 1'b1;
		do begin
			@(negedge aclk);
		end while (!rvalid);
		data = rdata;
		resp = axi_lite_pkg::axi_resp_e'(rresp);
		@(posedge aclk);
		rready <= 1'b0;
	endtask

	task automatic poll_lsr(input int port, input logic [7:0] mask);
		logic [31:0] lsr;
		axi_lite_pkg::axi_resp_e resp;
		int start;
		start = cycles;
		lsr = '0;
		while ((lsr[7:0] & mask) == 8'h00) begin
			if (cycles - start > POLL_LIMIT)
				stop_on_error($sformatf("LSR of port %0d never showed mask %02h", port, mask));
			read_register(reg_address(port, int'(uart_pkg::REG_LSR)), lsr, resp);
			check_resp("axi_s_rresp_o", resp, axi_lite_pkg::OKAY);
		end
	endtask

	initial begin
		logic [15:0] op;
		int port;
		int index;
		logic [7:0] data;
		logic [7:0] exp_data;
		logic [31:0] got;
		axi_lite_pkg::axi_resp_e exp_resp;
		axi_lite_pkg::axi_resp_e resp;

		awaddr <= '0;
		awvalid <= 1'b0;
		wdata <= '0;
		wstrb <= '0;
		wvalid <= 1'b0;
		bready <= 1'b0;
		araddr <= '0;
		arvalid <= 1'b0;
		rready <= 1'b0;
		void'($urandom(73700));

		// words past the file end keep bit 15 set, no op code has it.
		for (int i = 0; i < MAX_WORDS; i++)
			stim_mem[i] = 16'h8000 | 16'(i);
		$readmemh("tests/multi_uart_stimulus.txt", stim_mem);
		records = 0;
		while (records < MAX_RECORDS && stim_mem[records * 6] < 16'h8000)
			records++;
		if (records == 0)
			stop_on_error("the stimulus file holds no records");
		cycle_limit = records * POLL_LIMIT + 100;

		do begin
			@(negedge aclk);
		end while (rst);

		for (int r = 0; r < records; r++) begin
			op = stim_mem[r * 6];
			port = int'(stim_mem[r * 6 + 1]);
			index = int'(stim_mem[r * 6 + 2]);
			data = stim_mem[r * 6 + 3][7:0];
			exp_data = stim_mem[r * 6 + 4][7:0];
			exp_resp = axi_lite_pkg::axi_resp_e'(stim_mem[r * 6 + 5][1:0]);
			case (op)
				16'h1: begin
					write_register(reg_address(port, index), data, resp);
					check_resp("axi_s_bresp_o", resp, exp_resp);
				end
				16'h2: begin
					read_register(reg_address(port, index), got, resp);
					check_resp("axi_s_rresp_o", resp, exp_resp);
					if (exp_resp == axi_lite_pkg::OKAY) // data of an error read is undefined.
						check_data("axi_s_rdata_o", got, exp_data);
				end
				16'h3: poll_lsr(port, data);
				16'h4: begin
					@(negedge aclk);
					check_irq(irq, exp_data[0]);
				end
				default: stop_on_error($sformatf("stimulus record %0d has an unknown op", r));
			endcase
		end

		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* multi_uart.f */
+incdir+hdl
hdl/axi_lite_pkg.sv
hdl/uart_pkg.sv
hdl/axi_byte_bridge.sv
hdl/uart_line.sv
hdl/uart_port.sv
hdl/multi_uart.sv
tests/clock_gen.sv
tests/multi_uart_assertions.sv
tests/multi_uart_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the multi_uart testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module multi_uart_tb -f multi_uart.f -o multi_uart_sim
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "build failed with status $build_status"
	exit 1
fi

./obj_dir/multi_uart_sim > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "TEST FAILED" "$log"; then
	echo "simulation reported a failure, see $log"
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "simulator exited with status $run_status"
	exit 1
fi

echo "simulation finished without failure"
exit 0

/* tests/multi_uart_stimulus.txt */
// op port reg data expect resp, all hex; resp 0 is OKAY, 2 is SLVERR.
// op 1 write data, 2 read and compare expect, 3 poll LSR until LSR & data, 4 check interrupt_o.
// reset values
2 0 5 00 60 0
2 0 1 00 00 0
2 0 7 00 00 0
2 1 5 00 60 0
2 1 1 00 00 0
2 1 7 00 00 0
2 2 5 00 60 0
2 2 1 00 00 0
2 2 7 00 00 0
2 3 5 00 60 0
2 3 1 00 00 0
2 3 7 00 00 0
4 0 0 00 00 0
// scratch per port
1 0 7 11 00 0
1 1 7 22 00 0
1 2 7 33 00 0
1 3 7 44 00 0
2 0 7 00 11 0
2 1 7 00 22 0
2 2 7 00 33 0
2 3 7 00 44 0
// loopback from port 0 to port 1
1 0 0 5a 00 0
2 0 5 00 20 0
3 1 0 01 00 0
2 1 0 00 5a 0
2 1 5 00 60 0
// overrun from port 2 to port 3
1 2 0 a1 00 0
1 2 0 b2 00 0
2 2 5 00 00 0
3 2 0 40 00 0
2 3 5 00 63 0
2 3 5 00 61 0
2 3 0 00 b2 0
2 3 5 00 60 0
// data ready interrupt on port 0, fed by port 3
1 0 1 01 00 0
4 0 0 00 00 0
1 3 0 77 00 0
3 0 0 01 00 0
4 0 0 00 01 0
2 0 0 00 77 0
4 0 0 00 00 0
1 0 1 00 00 0
// holding register empty interrupt on idle port 1
1 1 1 02 00 0
4 0 0 00 01 0
1 1 1 00 00 0
4 0 0 00 00 0
// unmapped index and port out of range
1 0 3 55 00 2
2 0 3 00 00 2
1 4 7 66 00 2
2 4 7 00 00 2
2 0 7 00 11 0
